//--- flowTypesPkg.sv
// Flow payload types

// ----------------------------------------------------------------------
// Payload definitions shared by the datapath
// ----------------------------------------------------------------------
package flowTypesPkg;

  // Payload width in bits
  localparam int DataWidth = 16;

  // One payload word as carried on every ready-valid link
  typedef logic [DataWidth-1:0] flowData_t;

endpackage : flowTypesPkg

//--- flowSchedPkg.sv
// Flow scheduler types

// ----------------------------------------------------------------------
// Scheduler state and burst counting
// ----------------------------------------------------------------------
package flowSchedPkg;

  // Scheduler FSM states
  // schedIdle  no flow holds data
  // schedBurst a flow is selected and being served
  typedef enum logic {
    schedIdle  = 1'b0,
    schedBurst = 1'b1
  } schedState_t;

  // Transfers within one burst, also the type of the burst length
  typedef logic [7:0] burstCount_t;

endpackage : flowSchedPkg

//--- flowInputFifo.sv
// Per-flow input FIFO
`timescale 1ns/1ps

module flowInputFifo #(
  // Number of entries, a power of two
  parameter int FifoDepth = 4
) (
  input  logic                    clk,
  input  logic                    arstN,

  // Push side
  input  logic                    pushValid,
  output logic                    pushReady,
  input  flowTypesPkg::flowData_t pushData,

  // Pop side
  output logic                    popValid,
  input  logic                    popReady,
  output flowTypesPkg::flowData_t popData
);

  import flowTypesPkg::*;

  localparam int PtrWidth = $clog2(FifoDepth);
  localparam int CountWidth = $clog2(FifoDepth + 1);

  // Circular storage, written on push and read at rdPtr
  flowData_t mem [FifoDepth];

  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0] count;
  logic                  full;
  logic                  doPush;
  logic                  doPop;

  // ----------------------------------------------------------------------
  // Handshake and status
  // ----------------------------------------------------------------------
  assign full = (count == CountWidth'(FifoDepth));
  assign popValid = (count != '0);

  // Full FIFO still takes a word when the head leaves on the same edge
  assign pushReady = !full || popReady;

  assign doPush = pushValid && pushReady;
  assign doPop = popValid && popReady;

  // Head of queue straight from storage
  assign popData = mem[rdPtr];

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // Power-of-two depth, so pointers wrap on their own
      if (doPush) begin
        wrPtr <= wrPtr + PtrWidth'(1);
      end
      if (doPop) begin
        rdPtr <= rdPtr + PtrWidth'(1);
      end
      case ({doPush, doPop})
        2'b10:   count <= count + CountWidth'(1);
        2'b01:   count <= count - CountWidth'(1);
        default: count <= count;
      endcase
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

endmodule : flowInputFifo

//--- flowMuxSelectUnstable.sv
// Ready-valid select mux
`timescale 1ns/1ps

module flowMuxSelectUnstable #(
  // Two or more flows
  parameter int NumFlows = 4
) (
  // Binary select, kept in range by the scheduler
  input  logic [$clog2(NumFlows)-1:0]                select,

  // Input flows
  input  logic [NumFlows-1:0]                        inValid,
  output logic [NumFlows-1:0]                        inReady,
  input  flowTypesPkg::flowData_t [NumFlows-1:0]     inData,

  // Output, stable only while select holds during a stall
  output logic                                       outValid,
  input  logic                                       outReady,
  output flowTypesPkg::flowData_t                    outData
);

  localparam int SelWidth = $clog2(NumFlows);

  // ----------------------------------------------------------------------
  // Zero-latency steering
  // ----------------------------------------------------------------------

  // Ready goes only to the selected input, all others see back-pressure
  always_comb begin
    for (int i = 0; i < NumFlows; i++) begin
      inReady[i] = outReady && (select == SelWidth'(i));
    end
  end

  // Forward valid and data of the selected input
  assign outValid = inValid[select];
  assign outData = inData[select];

endmodule : flowMuxSelectUnstable

//--- flowSelectCtrl.sv
// Round-robin burst scheduler
`timescale 1ns/1ps

module flowSelectCtrl #(
  // Two or more flows
  parameter int NumFlows = 4,
  // Transfers per burst, 1 to 255
  parameter flowSchedPkg::burstCount_t BurstLen = 8'd3
) (
  input  logic                        clk,
  input  logic                        arstN,

  // Valid of every FIFO head
  input  logic [NumFlows-1:0]         flowValid,
  // Ready seen by the selected flow
  input  logic                        muxReady,

  // Registered binary select into the mux
  output logic [$clog2(NumFlows)-1:0] select
);

  import flowSchedPkg::*;

  localparam int SelWidth = $clog2(NumFlows);

  schedState_t         state;
  schedState_t         stateNext;
  logic [SelWidth-1:0] selectNext;
  logic [SelWidth-1:0] nextSel;
  burstCount_t         count;
  burstCount_t         countNext;
  logic                xfer;
  logic                anyValid;

  // ----------------------------------------------------------------------
  // Round-robin pick
  // ----------------------------------------------------------------------

  // First valid flow after cur, cur itself last; cur when none is valid
  function automatic logic [SelWidth-1:0] rrPick(input logic [SelWidth-1:0] cur,
                                                  input logic [NumFlows-1:0] valid);
    logic [SelWidth-1:0] pick;
    int                  idx;
    pick = cur;
    // Walk from the farthest offset down so the nearest one wins
    for (int k = NumFlows; k >= 1; k--) begin
      idx = (int'(cur) + k) % NumFlows;
      if (valid[idx]) begin
        pick = SelWidth'(idx);
      end
    end
    return pick;
  endfunction

  assign nextSel = rrPick(select, flowValid);
  assign anyValid = |flowValid;

  // One item crossed the mux on this edge
  assign xfer = flowValid[select] && muxReady;

  // ----------------------------------------------------------------------
  // Next-state logic
  // ----------------------------------------------------------------------
  always_comb begin
    stateNext = state;
    selectNext = select;
    countNext = count;
    unique case (state)
      schedIdle: begin
        // Count is clear here
        if (anyValid) begin
          stateNext = schedBurst;
          if (!flowValid[select]) begin
            selectNext = nextSel;
          end else if (xfer) begin
            // Parked select already passed an item, count it toward the burst
            if (BurstLen == burstCount_t'(1)) begin
              selectNext = nextSel;
            end else begin
              countNext = burstCount_t'(1);
            end
          end
        end
      end
      schedBurst: begin
        if (xfer) begin
          // Burst done, hand over on the transfer edge
          if (count == BurstLen - burstCount_t'(1)) begin
            selectNext = nextSel;
            countNext = '0;
          end else begin
            countNext = count + burstCount_t'(1);
          end
        end else if (!flowValid[select]) begin
          // Selected flow ran dry
          countNext = '0;
          if (anyValid) begin
            selectNext = nextSel;
          end else begin
            stateNext = schedIdle;
          end
        end
        // Valid but stalled falls through and holds select
      end
      default: stateNext = schedIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= schedIdle;
      select <= '0;
      count <= '0;
    end else begin
      state <= stateNext;
      select <= selectNext;
      count <= countNext;
    end
  end

endmodule : flowSelectCtrl

//--- flowPopRegister.sv
// Registered pop stage
`timescale 1ns/1ps

module flowPopRegister #(
  // Two or more flows, sets the tag width
  parameter int NumFlows = 4
) (
  input  logic                        clk,
  input  logic                        arstN,

  // From the mux, tagged with the select
  input  logic                        inValid,
  output logic                        inReady,
  input  flowTypesPkg::flowData_t     inData,
  input  logic [$clog2(NumFlows)-1:0] inFlow,

  // Pop interface
  output logic                        outValid,
  input  logic                        outReady,
  output flowTypesPkg::flowData_t     outData,
  output logic [$clog2(NumFlows)-1:0] outFlow
);

  logic load;

  // Empty or draining this edge, so full throughput
  assign inReady = !outValid || outReady;
  assign load = inValid && inReady;

  // ----------------------------------------------------------------------
  // Valid flag
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (load) begin
      outValid <= 1'b1;
    end else if (outReady) begin
      // Pop with nothing behind it
      outValid <= 1'b0;
    end
  end

  // Payload and tag, held while outValid and not outReady
  always_ff @(posedge clk) begin
    if (load) begin
      outData <= inData;
      outFlow <= inFlow;
    end
  end

endmodule : flowPopRegister

//--- flowMerge.sv
// Four-flow merge top level
`timescale 1ns/1ps

module flowMerge #(
  // Two or more flows
  parameter int NumFlows = 4,
  // Entries per input FIFO, a power of two
  parameter int FifoDepth = 4,
  // Transfers per burst, 1 to 255
  parameter flowSchedPkg::burstCount_t BurstLen = 8'd3
) (
  input  logic                                   clk,
  input  logic                                   arstN,

  // Push side, one lane per flow
  input  logic [NumFlows-1:0]                    pushValid,
  output logic [NumFlows-1:0]                    pushReady,
  input  flowTypesPkg::flowData_t [NumFlows-1:0] pushData,

  // Merged pop side with source flow tag
  output logic                                   popValid,
  input  logic                                   popReady,
  output flowTypesPkg::flowData_t                popData,
  output logic [$clog2(NumFlows)-1:0]            popFlow
);

  import flowTypesPkg::*;

  localparam int SelWidth = $clog2(NumFlows);

  // FIFO heads toward the mux
  logic [NumFlows-1:0]              fifoValid;
  logic [NumFlows-1:0]              fifoReady;
  flowData_t [NumFlows-1:0]         fifoData;

  // Mux output toward the pop register
  logic [SelWidth-1:0]              select;
  logic                             muxValid;
  logic                             muxReady;
  flowData_t                        muxData;

  // ----------------------------------------------------------------------
  // Input buffering
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NumFlows; i++) begin : fifoGen
    flowInputFifo #(
      .FifoDepth(FifoDepth)
    ) uFifo (
      .clk      (clk),
      .arstN    (arstN),
      .pushValid(pushValid[i]),
      .pushReady(pushReady[i]),
      .pushData (pushData[i]),
      .popValid (fifoValid[i]),
      .popReady (fifoReady[i]),
      .popData  (fifoData[i])
    );
  end

  // ----------------------------------------------------------------------
  // Scheduling and steering
  // ----------------------------------------------------------------------
  flowSelectCtrl #(
    .NumFlows(NumFlows),
    .BurstLen(BurstLen)
  ) uSelectCtrl (
    .clk      (clk),
    .arstN    (arstN),
    .flowValid(fifoValid),
    .muxReady (muxReady),
    .select   (select)
  );

  flowMuxSelectUnstable #(
    .NumFlows(NumFlows)
  ) uMux (
    .select  (select),
    .inValid (fifoValid),
    .inReady (fifoReady),
    .inData  (fifoData),
    .outValid(muxValid),
    .outReady(muxReady),
    .outData (muxData)
  );

  // Select doubles as the flow tag of the item it steers
  flowPopRegister #(
    .NumFlows(NumFlows)
  ) uPopReg (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (muxValid),
    .inReady (muxReady),
    .inData  (muxData),
    .inFlow  (select),
    .outValid(popValid),
    .outReady(popReady),
    .outData (popData),
    .outFlow (popFlow)
  );

endmodule : flowMerge

//--- flowMerge_assertions.sv
// Flow merge protocol checker
`timescale 1ns/1ps

module flowMergeAssertions #(
  parameter int NumFlows = 4
) (
  input logic                          clk,
  input logic                          arstN,
  input logic                          popValid,
  input logic                          popReady,
  input flowTypesPkg::flowData_t       popData,
  input logic [$clog2(NumFlows)-1:0]   popFlow,
  input logic [$clog2(NumFlows)-1:0]   select,
  input logic [NumFlows-1:0]           fifoValid,
  input logic [NumFlows-1:0]           fifoReady,
  input flowSchedPkg::schedState_t     schedState
);

  import flowSchedPkg::*;

  // ----------------------------------------------------------------------
  // Pop interface holds under back-pressure
  // ----------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (!arstN)
    popValid && !popReady |=> popValid && $stable(popData) && $stable(popFlow))
    else $error("pop interface changed while stalled");

  // Select stays put while the selected FIFO is stalled
  assert property (@(posedge clk) disable iff (!arstN)
    fifoValid[select] && !fifoReady[select] |=> $stable(select))
    else $error("select moved during a stall");

  // First cycle out of reset
  assert property (@(posedge clk)
    $rose(arstN) |-> !popValid && schedState == schedIdle && select == '0)
    else $error("pop side or scheduler not idle after reset");

endmodule : flowMergeAssertions

bind flowMerge flowMergeAssertions #(.NumFlows(NumFlows)) uAssertions (
  .clk       (clk),
  .arstN     (arstN),
  .popValid  (popValid),
  .popReady  (popReady),
  .popData   (popData),
  .popFlow   (popFlow),
  .select    (select),
  .fifoValid (fifoValid),
  .fifoReady (fifoReady),
  .schedState(uSelectCtrl.state)
);

//--- flowMerge_tb.sv
// Flow merge testbench
`timescale 1ns/1ps

module flowMerge_tb;

  import flowTypesPkg::*;

  // DUT defaults
  localparam int NumFlows = 4;
  localparam int FifoDepth = 4;
  localparam int BurstLen = 3;
  localparam int SelWidth = $clog2(NumFlows);
  localparam int DriveDelay = 2;
  // Items per flow in the order and load tests
  localparam int OrderItems = 6;
  localparam int LoadItems = 40;
  // Back-pressure and burst tests each fill every FIFO plus the output register
  localparam int TotalPushes = NumFlows * (OrderItems + LoadItems + 2 * (FifoDepth + 1));
  localparam int CycleLimit = 4 * TotalPushes + 500;

  logic                          clk;
  logic                          arstN;
  logic [NumFlows-1:0]           pushValid;
  logic [NumFlows-1:0]           pushReady;
  flowData_t [NumFlows-1:0]      pushData;
  logic                          popValid;
  logic                          popReady;
  flowData_t                     popData;
  logic [SelWidth-1:0]           popFlow;

  // Reference model with one queue per flow and the edge of each push
  flowData_t                     refQ [NumFlows][$];
  int                            pushEdge [NumFlows][$];

  logic [31:0]                   lfsrState;
  int                            cycleCount = 0;
  int                            errorCount;
  int                            checkCount;
  int                            expectFlow;
  logic                          fairCheck;
  int                            runFlow;
  int                            runLength;
  int                            waitBursts [NumFlows];
  logic                          stallSeen;
  flowData_t                     stallData;
  logic [SelWidth-1:0]           stallFlow;

  flowMerge uut (
    .clk      (clk),
    .arstN    (arstN),
    .pushValid(pushValid),
    .pushReady(pushReady),
    .pushData (pushData),
    .popValid (popValid),
    .popReady (popReady),
    .popData  (popData),
    .popFlow  (popFlow)
  );

  initial begin : clockGen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycleCount++;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] randomBits(input int width);
    logic [31:0] value;
    value = '0;
    for (int b = 0; b < width; b++) begin
      value = {value[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
    end
    return value;
  endfunction

  // Expected next output of a flow
  function automatic flowData_t expectedHead(input int flow);
    return refQ[flow][0];
  endfunction

  function automatic int pendingItems();
    int total;
    total = 0;
    for (int i = 0; i < NumFlows; i++) begin
      total += refQ[i].size();
    end
    return total;
  endfunction

  function automatic logic otherPending(input int flow);
    logic found;
    found = 1'b0;
    for (int i = 0; i < NumFlows; i++) begin
      if (i != flow && refQ[i].size() != 0) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #DriveDelay;
  endtask

  // All pushed items have left the pop interface
  task automatic waitDrained();
    do begin
      @(posedge clk);
    end while (pendingItems() != 0);
    #DriveDelay;
  endtask

  task automatic reportTest(input int num, input string name, input int errorsBefore);
    $display("test %0d %s: %0d errors", num, name, errorCount - errorsBefore);
  endtask

  // Run length and waiting bursts of the pop sequence
  task automatic trackFairness(input int flow);
    if (flow == runFlow) begin
      runLength++;
    end else begin
      // Every other flow with items waits one more burst
      for (int j = 0; j < NumFlows; j++) begin
        if (j != flow && refQ[j].size() != 0) begin
          waitBursts[j]++;
        end
      end
      waitBursts[flow] = 0;
      runFlow = flow;
      runLength = 1;
    end
    if (runLength > BurstLen && otherPending(flow)) begin
      errorCount++;
      $display("flow %0d kept the output for %0d pops while other flows waited",
               flow, runLength);
    end
    for (int j = 0; j < NumFlows; j++) begin
      if (waitBursts[j] >= NumFlows) begin
        errorCount++;
        $display("flow %0d was passed over for %0d bursts", j, waitBursts[j]);
        waitBursts[j] = 0;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Compare process on the falling edge between drive and capture
  // ----------------------------------------------------------------------
  always @(negedge clk) begin : monitor
    int flow;
    if (arstN === 1'b1) begin
      if (stallSeen) begin
        checkEqual(popValid, 1'b1, "popValid dropped during stall");
        checkEqual(popData, stallData, "popData moved during stall");
        checkEqual(popFlow, stallFlow, "popFlow moved during stall");
      end
      stallSeen = popValid && !popReady;
      stallData = popData;
      stallFlow = popFlow;
      if (popValid && popReady) begin
        flow = int'(popFlow);
        if (expectFlow >= 0) begin
          checkEqual(flow, expectFlow, "popFlow differs from the active flow");
        end
        if (refQ[flow].size() == 0) begin
          errorCount++;
          $display("pop at %0t from flow %0d, which has no item outstanding", $time, flow);
        end else begin
          checkEqual(popData, expectedHead(flow), "popData is not the head of its flow");
          // One cycle in the FIFO and one in the output register
          checkEqual(cycleCount - pushEdge[flow][0] >= 2, 1'b1, "pop too soon after push");
          void'(refQ[flow].pop_front());
          void'(pushEdge[flow].pop_front());
          if (fairCheck) begin
            trackFairness(flow);
          end
        end
      end
      for (int i = 0; i < NumFlows; i++) begin
        if (pushValid[i] && pushReady[i]) begin
          refQ[i].push_back(pushData[i]);
          pushEdge[i].push_back(cycleCount);
        end
      end
    end
  end

  initial begin : watchdog
    wait (cycleCount >= CycleLimit);
    $display("timeout: run did not finish within %0d cycles", CycleLimit);
    $display("TEST FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : mainSeq
    int                  accepted;
    int                  blocked;
    int                  errorsBefore;
    int                  left [NumFlows];
    logic [NumFlows-1:0] taken;
    arstN = 1'b0;
    pushValid = '0;
    pushData = '0;
    popReady = 1'b0;
    lfsrState = 32'h6a52;
    errorCount = 0;
    checkCount = 0;
    expectFlow = -1;
    fairCheck = 1'b0;
    runFlow = -1;
    runLength = 0;
    stallSeen = 1'b0;
    repeat (3) @(posedge clk);
    #DriveDelay;
    arstN = 1'b1;

    // Reset values
    errorsBefore = errorCount;
    nextCycle();
    checkEqual(popValid, 1'b0, "popValid after reset");
    checkEqual(pushReady, {NumFlows{1'b1}}, "pushReady after reset");
    reportTest(1, "reset values", errorsBefore);

    // One flow at a time with the output always ready
    errorsBefore = errorCount;
    popReady = 1'b1;
    for (int f = 0; f < NumFlows; f++) begin
      expectFlow = f;
      for (int n = 0; n < OrderItems; n++) begin
        pushValid[f] = 1'b1;
        pushData[f] = DataWidth'(randomBits(DataWidth));
        do begin
          @(negedge clk);
          accepted = int'(pushReady[f]);
          nextCycle();
        end while (accepted == 0);
      end
      pushValid[f] = 1'b0;
      waitDrained();
    end
    expectFlow = -1;
    reportTest(2, "per-flow order", errorsBefore);

    // Random pushes on all flows against a random pop side
    errorsBefore = errorCount;
    foreach (left[f]) left[f] = LoadItems;
    while (left.sum() != 0) begin
      for (int f = 0; f < NumFlows; f++) begin
        if (!pushValid[f] && left[f] > 0) begin
          pushValid[f] = (randomBits(1) != 0);
          pushData[f] = DataWidth'(randomBits(DataWidth));
        end
      end
      popReady = |randomBits(2);
      @(negedge clk);
      taken = pushValid & pushReady;
      nextCycle();
      for (int f = 0; f < NumFlows; f++) begin
        if (taken[f]) begin
          pushValid[f] = 1'b0;
          left[f]--;
        end
      end
    end
    popReady = 1'b1;
    waitDrained();
    reportTest(3, "integrity under load", errorsBefore);

    // Fill each flow until its push side stalls
    errorsBefore = errorCount;
    for (int f = 0; f < NumFlows; f++) begin
      popReady = 1'b0;
      accepted = 0;
      blocked = 0;
      pushValid[f] = 1'b1;
      pushData[f] = DataWidth'(randomBits(DataWidth));
      while (blocked < 4) begin
        @(negedge clk);
        taken[f] = pushReady[f];
        nextCycle();
        if (taken[f]) begin
          accepted++;
          blocked = 0;
          pushData[f] = DataWidth'(randomBits(DataWidth));
        end else begin
          blocked++;
        end
      end
      pushValid[f] = 1'b0;
      // FIFO entries plus the output register
      checkEqual(accepted, FifoDepth + 1, "items accepted under back-pressure");
      checkEqual(popValid, 1'b1, "popValid while stalled");
      checkEqual(popFlow, f, "popFlow while stalled");
      checkEqual(popData, expectedHead(f), "popData while stalled");
      popReady = 1'b1;
      waitDrained();
    end
    reportTest(4, "back-pressure", errorsBefore);

    // Preload all flows and drain at full rate
    errorsBefore = errorCount;
    popReady = 1'b0;
    pushValid = '1;
    for (int f = 0; f < NumFlows; f++) begin
      pushData[f] = DataWidth'(randomBits(DataWidth));
    end
    blocked = 0;
    while (blocked < 4) begin
      @(negedge clk);
      taken = pushValid & pushReady;
      nextCycle();
      blocked = (taken != '0) ? 0 : blocked + 1;
      for (int f = 0; f < NumFlows; f++) begin
        if (taken[f]) begin
          pushData[f] = DataWidth'(randomBits(DataWidth));
        end
      end
    end
    pushValid = '0;
    checkEqual(pendingItems(), NumFlows * FifoDepth + 1, "items preloaded");
    foreach (waitBursts[j]) waitBursts[j] = 0;
    runFlow = -1;
    fairCheck = 1'b1;
    popReady = 1'b1;
    waitDrained();
    fairCheck = 1'b0;
    reportTest(5, "burst fairness", errorsBefore);

    for (int f = 0; f < NumFlows; f++) begin
      if (refQ[f].size() != 0) begin
        errorCount++;
        $display("flow %0d still has %0d items that never came out", f, refQ[f].size());
      end
    end
    $display("tests 5, checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : flowMerge_tb

//--- flowMerge.f
flowTypesPkg.sv
flowSchedPkg.sv
flowInputFifo.sv
flowMuxSelectUnstable.sv
flowSelectCtrl.sv
flowPopRegister.sv
flowMerge.sv
flowMerge_assertions.sv
flowMerge_tb.sv

//--- Makefile
# Verilator build and run for the flow merge unit

VERILATOR ?= verilator
TOP       := flowMerge_tb
FILELIST  := flowMerge.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Fails unless the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
